// File: clause_array.f
+incdir+src
src/clause_array_pkg.sv
src/learnt_slot_select.sv
src/clause_store.sv
src/clause_eval.sv
src/clause_array.sv
test/clause_array_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= clause_array_tb
FILELIST  ?= clause_array.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/clause_array_tb.sv
`include "clause_array_settings.svh"

module clause_array_tb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef clause_array_pkg::clause_t     clause_t;
    typedef clause_array_pkg::clause_vec_t clause_vec_t;
    typedef clause_array_pkg::var_vec_t    var_vec_t;
    typedef clause_array_pkg::var_state_t  var_state_t;
    typedef clause_array_pkg::lit_e        lit_e;

    localparam int N          = `CA_NUM_CLAUSES;
    localparam int NL         = `CA_NUM_CLAUSES / 2;
    localparam int NV         = `CA_NUM_VARS;
    localparam int CLK_PERIOD = 4;
    localparam int NUM_RANDOM = 300;

    logic         clk = 1'b0;
    logic         arst_n_i;
    var_vec_t     var_value_i;
    var_vec_t     var_value_o;
    logic [N-1:0] wr_i;
    logic [N-1:0] rd_i;
    clause_t      clause_i;
    clause_t      clause_o;
    logic         add_learnt_en_i;
    logic         all_c_sat_o;
    logic         conflict_o;
    logic         apply_impl_i;
    logic         apply_bkt_i;

    int seed   = 32'h80cc986e;
    int errors = 0;

    // Reference model state and expectations.
    clause_vec_t  m_slots      = '0;
    logic [N-1:0] m_valid      = '0;
    clause_t      exp_clause   = '0;
    logic         exp_all_sat  = 1'b1;
    logic         exp_conflict = 1'b0;
    var_vec_t     exp_vars     = '0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    clause_array UUT (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .var_value_i     (var_value_i),
        .var_value_o     (var_value_o),
        .wr_i            (wr_i),
        .rd_i            (rd_i),
        .clause_i        (clause_i),
        .clause_o        (clause_o),
        .add_learnt_en_i (add_learnt_en_i),
        .all_c_sat_o     (all_c_sat_o),
        .conflict_o      (conflict_o),
        .apply_impl_i    (apply_impl_i),
        .apply_bkt_i     (apply_bkt_i)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [N-1:0] onehot(input int s);
        logic [N-1:0] oh;
        oh    = '0;
        oh[s] = 1'b1;
        return oh;
    endfunction

    function automatic logic lit_holds(input lit_e l, input var_state_t s);
        return s.assigned && ((l == clause_array_pkg::LIT_POS && s.value) ||
                              (l == clause_array_pkg::LIT_NEG && !s.value));
    endfunction

    function automatic logic lit_open(input lit_e l, input var_state_t s);
        return (l != clause_array_pkg::LIT_ABSENT) && !s.assigned;
    endfunction

    // Empty learnt slot first, else the longest, lowest index on ties.
    function automatic int pick_learnt(input clause_vec_t s, input logic [N-1:0] v);
        int best;
        best = -1;
        for (int i = N - 1; i >= NL; i--) begin
            if (!v[i]) begin
                best = i;
            end
        end
        if (best < 0) begin
            best = NL;
            for (int i = NL + 1; i < N; i++) begin
                if (s[i].len > s[best].len) begin
                    best = i;
                end
            end
        end
        return best;
    endfunction

    function automatic clause_t expected_read(input clause_vec_t s, input logic [N-1:0] v,
                                              input logic [N-1:0] rd);
        clause_t c;
        c = '0;
        for (int i = 0; i < N; i++) begin
            if (rd[i] && v[i]) begin
                c = s[i];
            end
        end
        return c;
    endfunction

    function automatic logic all_satisfied(input clause_vec_t s, input logic [N-1:0] v,
                                           input var_vec_t x);
        logic ok;
        logic hit;
        ok = 1'b1;
        for (int c = 0; c < N; c++) begin
            hit = 1'b0;
            for (int k = 0; k < NV; k++) begin
                hit = hit | lit_holds(s[c].lits[k], x[k]);
            end
            if (v[c] && !hit) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    function automatic logic any_conflict(input clause_vec_t s, input logic [N-1:0] v,
                                          input var_vec_t x);
        logic found;
        logic hit;
        logic open;
        found = 1'b0;
        for (int c = 0; c < N; c++) begin
            hit  = 1'b0;
            open = 1'b0;
            for (int k = 0; k < NV; k++) begin
                hit  = hit | lit_holds(s[c].lits[k], x[k]);
                open = open | lit_open(s[c].lits[k], x[k]);
            end
            if (v[c] && !hit && !open) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    function automatic var_vec_t implied_update(input clause_vec_t s, input logic [N-1:0] v,
                                                input var_vec_t x, input logic impl,
                                                input logic bkt);
        var_vec_t      nx;
        logic [NV-1:0] forced;
        int            n_hold;
        int            n_open;
        int            fv;
        logic          fpos;
        nx     = x;
        forced = '0;
        if (bkt) begin
            for (int k = 0; k < NV; k++) begin
                if (x[k].implied) begin
                    nx[k] = '0;
                end
            end
        end else if (impl) begin
            // Lower clauses claim a variable first.
            for (int c = 0; c < N; c++) begin
                n_hold = 0;
                n_open = 0;
                fv     = 0;
                fpos   = 1'b0;
                for (int k = 0; k < NV; k++) begin
                    if (lit_holds(s[c].lits[k], x[k])) begin
                        n_hold++;
                    end
                    if (lit_open(s[c].lits[k], x[k])) begin
                        n_open++;
                        fv   = k;
                        fpos = (s[c].lits[k] == clause_array_pkg::LIT_POS);
                    end
                end
                if (v[c] && n_hold == 0 && n_open == 1 && !forced[fv]) begin
                    forced[fv]      = 1'b1;
                    nx[fv].assigned = 1'b1;
                    nx[fv].value    = fpos;
                    nx[fv].implied  = 1'b1;
                end
            end
        end
        return nx;
    endfunction

    always @(posedge clk or negedge arst_n_i) begin
        logic [N-1:0] sel;
        if (!arst_n_i) begin
            m_valid      <= '0;
            exp_clause   <= '0;
            exp_all_sat  <= 1'b1;
            exp_conflict <= 1'b0;
            exp_vars     <= '0;
        end else begin
            sel = add_learnt_en_i ? onehot(pick_learnt(m_slots, m_valid)) : wr_i;
            for (int i = 0; i < N; i++) begin
                if (sel[i]) begin
                    m_slots[i] <= clause_i;
                end
            end
            m_valid      <= m_valid | sel;
            exp_clause   <= expected_read(m_slots, m_valid, rd_i);
            exp_all_sat  <= all_satisfied(m_slots, m_valid, var_value_i);
            exp_conflict <= any_conflict(m_slots, m_valid, var_value_i);
            exp_vars     <= implied_update(m_slots, m_valid, var_value_i,
                                           apply_impl_i, apply_bkt_i);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    check_clause: assert property (@(posedge clk) disable iff (!arst_n_i)
        clause_o == exp_clause)
        else begin
            errors++;
            $display("** Error at %0t: clause_o is %h, expected %h",
                     $time, $sampled(clause_o), $sampled(exp_clause));
        end

    check_sat: assert property (@(posedge clk) disable iff (!arst_n_i)
        all_c_sat_o == exp_all_sat)
        else begin
            errors++;
            $display("** Error at %0t: all_c_sat_o is %b, expected %b",
                     $time, $sampled(all_c_sat_o), $sampled(exp_all_sat));
        end

    check_conflict: assert property (@(posedge clk) disable iff (!arst_n_i)
        conflict_o == exp_conflict)
        else begin
            errors++;
            $display("** Error at %0t: conflict_o is %b, expected %b",
                     $time, $sampled(conflict_o), $sampled(exp_conflict));
        end

    check_vars: assert property (@(posedge clk) disable iff (!arst_n_i)
        var_value_o == exp_vars)
        else begin
            errors++;
            $display("** Error at %0t: var_value_o is %h, expected %h",
                     $time, $sampled(var_value_o), $sampled(exp_vars));
        end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic clause_t random_clause(input int len);
        clause_t     c;
        logic [31:0] r;
        c = '0;
        for (int k = 0; k < NV; k++) begin
            r = $random(seed);
            case (r % 3)
                0:       c.lits[k] = clause_array_pkg::LIT_ABSENT;
                1:       c.lits[k] = clause_array_pkg::LIT_POS;
                default: c.lits[k] = clause_array_pkg::LIT_NEG;
            endcase
        end
        c.len = len[`CA_LEN_W-1:0];
        return c;
    endfunction

    // Clause (x_p | ~x_n).
    function automatic clause_t pair_clause(input int p, input int n);
        clause_t c;
        c         = '0;
        c.lits[p] = clause_array_pkg::LIT_POS;
        c.lits[n] = clause_array_pkg::LIT_NEG;
        c.len     = 2;
        return c;
    endfunction

    function automatic var_vec_t make_vars(input logic [NV-1:0] asg,
                                           input logic [NV-1:0] val,
                                           input logic [NV-1:0] imp);
        var_vec_t x;
        for (int k = 0; k < NV; k++) begin
            x[k].assigned = asg[k];
            x[k].value    = val[k];
            x[k].implied  = imp[k];
        end
        return x;
    endfunction

    task automatic clear_strobes();
        wr_i            <= '0;
        rd_i            <= '0;
        add_learnt_en_i <= 1'b0;
        apply_impl_i    <= 1'b0;
        apply_bkt_i     <= 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            clear_strobes();
        end
    endtask

    task automatic write_slot(input int s, input clause_t c);
        @(posedge clk);
        clear_strobes();
        wr_i     <= onehot(s);
        clause_i <= c;
    endtask

    task automatic read_all();
        for (int i = 0; i < N; i++) begin
            @(posedge clk);
            clear_strobes();
            rd_i <= onehot(i);
        end
    endtask

    task automatic add_learnt(input clause_t c, input logic [N-1:0] also_wr);
        @(posedge clk);
        clear_strobes();
        add_learnt_en_i <= 1'b1;
        wr_i            <= also_wr;
        clause_i        <= c;
    endtask

    task automatic drive_vars(input var_vec_t x, input logic impl, input logic bkt);
        @(posedge clk);
        clear_strobes();
        var_value_i  <= x;
        apply_impl_i <= impl;
        apply_bkt_i  <= bkt;
    endtask

    // Watchdog.
    initial begin
        #((NUM_RANDOM + 200) * CLK_PERIOD);
        $display("Timeout: the test did not complete within the time limit");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] q;
        arst_n_i        = 1'b0;
        var_value_i     = '0;
        wr_i            = '0;
        rd_i            = '0;
        clause_i        = '0;
        add_learnt_en_i = 1'b0;
        apply_impl_i    = 1'b0;
        apply_bkt_i     = 1'b0;
        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;
        idle(2);

        // Originals, then read back all slots.
        for (int i = 0; i < NL; i++) begin
            write_slot(i, random_clause(i + 1));
        end
        read_all();

        // Fill learnt slots, then replace by length.
        add_learnt(random_clause(3), '0);
        add_learnt(random_clause(7), '0);
        add_learnt(random_clause(7), onehot(1));
        add_learnt(random_clause(2), '0);
        read_all();
        add_learnt(random_clause(1), '0);
        add_learnt(random_clause(5), '0);
        read_all();

        for (int k = 0; k < NUM_RANDOM; k++) begin
            r = $random(seed);
            q = $random(seed);
            @(posedge clk);
            clear_strobes();
            var_value_i  <= var_vec_t'(r[$bits(var_vec_t)-1:0]);
            apply_impl_i <= (r[25:24] == 2'b00);
            apply_bkt_i  <= (r[28:26] == 3'b000);
            if (q[3:0] == 4'h0) begin
                wr_i     <= onehot(int'(q[6:4]));
                clause_i <= random_clause(int'(q[11:8]));
            end else if (q[3:0] == 4'h1) begin
                add_learnt_en_i <= 1'b1;
                clause_i        <= random_clause(int'(q[11:8]));
            end
            if (q[12]) begin
                rd_i <= onehot(int'(q[15:13]));
            end
        end

        // Slot i holds (x_i | ~x_(i+1)).
        for (int i = 0; i < N; i++) begin
            write_slot(i, pair_clause(i % NV, (i + 1) % NV));
        end
        drive_vars(make_vars(8'hFF, 8'hFF, 8'h00), 1'b0, 1'b0);
        drive_vars(make_vars(8'hFF, 8'hFE, 8'h00), 1'b0, 1'b0);
        // x1 open, slots 0 and 1 force it both ways.
        drive_vars(make_vars(8'hFD, 8'hFE, 8'h08), 1'b1, 1'b0);
        drive_vars(make_vars(8'hFF, 8'hF8, 8'h26), 1'b0, 1'b1);
        drive_vars(make_vars(8'hFD, 8'hFE, 8'h26), 1'b1, 1'b1);
        idle(3);

        $display("Checks done, error count: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: src/clause_array.sv
`include "clause_array_settings.svh"

module clause_array (
    input  logic                       clk,
    input  logic                       arst_n_i,

    input  clause_array_pkg::var_vec_t var_value_i,
    output clause_array_pkg::var_vec_t var_value_o,

    input  logic [`CA_NUM_CLAUSES-1:0] wr_i,
    input  logic [`CA_NUM_CLAUSES-1:0] rd_i,
    input  clause_array_pkg::clause_t  clause_i,
    output clause_array_pkg::clause_t  clause_o,

    input  logic                       add_learnt_en_i,
    output logic                       all_c_sat_o,
    output logic                       conflict_o,
    input  logic                       apply_impl_i,
    input  logic                       apply_bkt_i
);

    localparam int N  = `CA_NUM_CLAUSES;
    localparam int NL = `CA_NUM_CLAUSES / 2;

    logic [N-1:0]                      wr_sel;
    clause_array_pkg::clause_vec_t     slots;
    logic [N-1:0]                      valid;
    clause_array_pkg::learnt_len_vec_t learnt_len;
    logic [NL-1:0]                     learnt_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Learnt half taps
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NL; i++) begin : g_learnt_len
        assign learnt_len[i] = slots[NL+i].len;
    end

    assign learnt_valid = valid[N-1:NL];

    learnt_slot_select u_learnt_slot_select (
        .wr_i            (wr_i),
        .add_learnt_en_i (add_learnt_en_i),
        .slot_len_i      (learnt_len),
        .slot_valid_i    (learnt_valid),
        .wr_sel_o        (wr_sel)
    );

    clause_store u_clause_store (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wr_sel_i (wr_sel),
        .rd_i     (rd_i),
        .clause_i (clause_i),
        .clause_o (clause_o),
        .slots_o  (slots),
        .valid_o  (valid)
    );

    clause_eval u_clause_eval (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .slots_i      (slots),
        .valid_i      (valid),
        .var_value_i  (var_value_i),
        .apply_impl_i (apply_impl_i),
        .apply_bkt_i  (apply_bkt_i),
        .var_value_o  (var_value_o),
        .all_c_sat_o  (all_c_sat_o),
        .conflict_o   (conflict_o)
    );

endmodule

// File: src/clause_eval.sv
`include "clause_array_settings.svh"

module clause_eval (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  clause_array_pkg::clause_vec_t slots_i,
    input  logic [`CA_NUM_CLAUSES-1:0]    valid_i,
    input  clause_array_pkg::var_vec_t    var_value_i,
    input  logic                          apply_impl_i,
    input  logic                          apply_bkt_i,
    output clause_array_pkg::var_vec_t    var_value_o,
    output logic                          all_c_sat_o,
    output logic                          conflict_o
);

    localparam int N         = `CA_NUM_CLAUSES;
    localparam int NV        = `CA_NUM_VARS;
    localparam int VAR_IDX_W = $clog2(NV);

    logic [N-1:0]           sat;
    logic [N-1:0]           confl;
    logic [N-1:0]           unit;
    logic [VAR_IDX_W-1:0]   unit_var [N];
    logic [N-1:0]           unit_val;

    logic                       all_sat_d;
    logic                       conflict_d;
    clause_array_pkg::var_vec_t var_d;

    logic                       all_sat_q;
    logic                       conflict_q;
    clause_array_pkg::var_vec_t var_q;

    ////////////////////////////////////////////////////////////////////////////
    // Per-clause evaluation
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        clause_array_pkg::lit_e       lit;
        clause_array_pkg::var_state_t st;
        logic                         present;
        logic                         pos;
        logic                         open_seen;
        logic                         multi_open;

        for (int c = 0; c < N; c++) begin
            sat[c]      = 1'b0;
            open_seen   = 1'b0;
            multi_open  = 1'b0;
            unit_var[c] = '0;
            unit_val[c] = 1'b0;
            for (int v = 0; v < NV; v++) begin
                lit     = slots_i[c].lits[v];
                st      = var_value_i[v];
                present = (lit != clause_array_pkg::LIT_ABSENT);
                pos     = (lit == clause_array_pkg::LIT_POS);
                if (present && st.assigned && (st.value == pos)) begin
                    sat[c] = 1'b1;
                end
                if (present && !st.assigned) begin
                    // Remember the open literal.
                    multi_open  = multi_open | open_seen;
                    open_seen   = 1'b1;
                    unit_var[c] = VAR_IDX_W'(v);
                    unit_val[c] = pos;
                end
            end
            // Empty clause counts as a conflict.
            confl[c] = !sat[c] && !open_seen;
            unit[c]  = !sat[c] && open_seen && !multi_open;
        end
    end

    assign all_sat_d  = &(sat | ~valid_i);
    assign conflict_d = |(confl & valid_i);

    ////////////////////////////////////////////////////////////////////////////
    // Variable update
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        var_d = var_value_i;
        if (apply_bkt_i) begin
            for (int v = 0; v < NV; v++) begin
                if (var_value_i[v].implied) begin
                    var_d[v] = '0;
                end
            end
        end else if (apply_impl_i) begin
            // Walk downwards so the lowest unit clause wins.
            for (int c = N - 1; c >= 0; c--) begin
                if (valid_i[c] && unit[c]) begin
                    var_d[unit_var[c]].assigned = 1'b1;
                    var_d[unit_var[c]].value    = unit_val[c];
                    var_d[unit_var[c]].implied  = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            all_sat_q  <= 1'b1;
            conflict_q <= 1'b0;
            var_q      <= '0;
        end else begin
            all_sat_q  <= all_sat_d;
            conflict_q <= conflict_d;
            var_q      <= var_d;
        end
    end

    assign all_c_sat_o = all_sat_q;
    assign conflict_o  = conflict_q;
    assign var_value_o = var_q;

endmodule

// File: src/clause_store.sv
`include "clause_array_settings.svh"

module clause_store (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic [`CA_NUM_CLAUSES-1:0]    wr_sel_i,
    input  logic [`CA_NUM_CLAUSES-1:0]    rd_i,
    input  clause_array_pkg::clause_t     clause_i,
    output clause_array_pkg::clause_t     clause_o,
    output clause_array_pkg::clause_vec_t slots_o,
    output logic [`CA_NUM_CLAUSES-1:0]    valid_o
);

    localparam int N = `CA_NUM_CLAUSES;

    clause_array_pkg::clause_vec_t slots_q;
    logic [N-1:0]                  valid_q;
    clause_array_pkg::clause_t     rd_clause;
    clause_array_pkg::clause_t     clause_q;

    ////////////////////////////////////////////////////////////////////////////
    // Slot registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (wr_sel_i[i]) begin
                slots_q[i] <= clause_i;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_q | wr_sel_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////////////////////

    // Empty clause when nothing is read or the slot is invalid.
    always_comb begin
        rd_clause = '0;
        for (int i = 0; i < N; i++) begin
            if (rd_i[i] && valid_q[i]) begin
                rd_clause = slots_q[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            clause_q <= '0;
        end else begin
            clause_q <= rd_clause;
        end
    end

    assign clause_o = clause_q;
    assign slots_o  = slots_q;
    assign valid_o  = valid_q;

endmodule

// File: src/learnt_slot_select.sv
`include "clause_array_settings.svh"

module learnt_slot_select (
    input  logic [`CA_NUM_CLAUSES-1:0]        wr_i,
    input  logic                              add_learnt_en_i,
    input  clause_array_pkg::learnt_len_vec_t slot_len_i,
    input  logic [`CA_NUM_CLAUSES/2-1:0]      slot_valid_i,
    output logic [`CA_NUM_CLAUSES-1:0]        wr_sel_o
);

    localparam int NL    = `CA_NUM_CLAUSES / 2;
    localparam int IDX_W = $clog2(NL);

    logic                     free_found;
    logic [IDX_W-1:0]         free_idx;
    clause_array_pkg::len_t   max_len;
    logic [IDX_W-1:0]         max_idx;
    logic [IDX_W-1:0]         victim_idx;
    logic [NL-1:0]            learnt_sel;

    // Lowest empty learnt slot.
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = NL - 1; i >= 0; i--) begin
            if (!slot_valid_i[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
        end
    end

    // Longest learnt clause, ties to the lowest index.
    always_comb begin
        max_len = slot_len_i[0];
        max_idx = '0;
        for (int i = 1; i < NL; i++) begin
            if (slot_len_i[i] > max_len) begin
                max_len = slot_len_i[i];
                max_idx = IDX_W'(i);
            end
        end
    end

    assign victim_idx = free_found ? free_idx : max_idx;

    always_comb begin
        learnt_sel             = '0;
        learnt_sel[victim_idx] = 1'b1;
    end

    // Learnt insertion overrides the external strobe.
    assign wr_sel_o = add_learnt_en_i ? {learnt_sel, {NL{1'b0}}} : wr_i;

endmodule

// File: src/clause_array_pkg.sv
`include "clause_array_settings.svh"

package clause_array_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Clause encoding
    ////////////////////////////////////////////////////////////////////////////

    // Literal code per variable position.
    typedef enum logic [1:0] {
        LIT_ABSENT = 2'b00,
        LIT_POS    = 2'b01,
        LIT_NEG    = 2'b10
    } lit_e;

    typedef logic [`CA_LEN_W-1:0] len_t;

    // Length is only used to pick a learnt slot to replace.
    typedef struct packed {
        lit_e [`CA_NUM_VARS-1:0] lits;
        len_t                    len;
    } clause_t;

    typedef clause_t [`CA_NUM_CLAUSES-1:0] clause_vec_t;

    // Lengths of the learnt half only.
    typedef len_t [`CA_NUM_CLAUSES/2-1:0] learnt_len_vec_t;

    ////////////////////////////////////////////////////////////////////////////
    // Variable state
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic assigned;
        logic value;
        logic implied;
    } var_state_t;

    typedef var_state_t [`CA_NUM_VARS-1:0] var_vec_t;

endpackage

// File: src/clause_array_settings.svh
`ifndef CLAUSE_ARRAY_SETTINGS_SVH
`define CLAUSE_ARRAY_SETTINGS_SVH

// Clause slots. Must be even, upper half is learnt.
`define CA_NUM_CLAUSES 8

// Variables, also literal positions per clause.
`define CA_NUM_VARS 8

// Width of a clause length.
`define CA_LEN_W 4

`endif
